// File: dv/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int dmem_addr_width = 12;
    localparam logic [31:0] mem_base = 32'h0000_0100;
    localparam int max_cycles = 3000;

    logic        clk;
    logic        reset;
    logic [31:0] ex_pc;
    logic [31:0] ex_inst;
    logic [31:0] ex_rd1;
    logic [31:0] ex_rd2;
    logic [31:0] ex_imm;
    logic        ex_br_taken;
    logic [31:0] ex_addr;
    logic [31:0] ex_din;
    logic [3:0]  ex_we;
    logic [31:0] wb_pc4;
    logic [31:0] wb_alu;
    logic [31:0] wb_inst;
    logic [31:0] wb_dmem_dout;
    logic        wb_flush;
    logic [31:0] tohost;

    integer      seed = 32'h24a;
    int          errors = 0;
    logic        done = 1'b0;

    // Reference model state
    logic [31:0] shadow [0:15];
    logic        exp_flush;
    logic [31:0] exp_tohost;

    tb_clock clock_gen (
        .clk (clk)
    );

    ex_stage #(
        .dmem_addr_width (dmem_addr_width)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .ex_pc        (ex_pc),
        .ex_inst      (ex_inst),
        .ex_rd1       (ex_rd1),
        .ex_rd2       (ex_rd2),
        .ex_imm       (ex_imm),
        .ex_br_taken  (ex_br_taken),
        .ex_addr      (ex_addr),
        .ex_din       (ex_din),
        .ex_we        (ex_we),
        .wb_pc4       (wb_pc4),
        .wb_alu       (wb_alu),
        .wb_inst      (wb_inst),
        .wb_dmem_dout (wb_dmem_dout),
        .wb_flush     (wb_flush),
        .tohost       (tohost)
    );

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Random register fields around a fixed opcode and funct3
    function automatic logic [31:0] make_inst(input logic [6:0] opc, input logic [2:0] f3);
        logic [31:0] r;
        r = rand32();
        return {r[31:15], f3, r[11:7], opc};
    endfunction

    // Immediate as the decode stage would hand it over
    function automatic logic [31:0] decode_imm(input logic [31:0] inst);
        case (inst[6:0])
            rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc: return {inst[31:12], 12'd0};
            rv_isa_pkg::op_jal:
                return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            rv_isa_pkg::op_branch:
                return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_isa_pkg::op_store:  return sext12({inst[31:25], inst[11:7]});
            rv_isa_pkg::op_system: return {27'd0, inst[19:15]};
            default:               return sext12(inst[31:20]);
        endcase
    endfunction

    function automatic logic [31:0] expected_result(input logic [31:0] inst,
            input logic [31:0] pc, input logic [31:0] rd1, input logic [31:0] rd2,
            input logic [31:0] imm);
        logic [31:0] b;
        logic [4:0]  sh;
        b  = (inst[6:0] == rv_isa_pkg::op_r) ? rd2 : imm;
        sh = b[4:0];
        case (inst[6:0])
            rv_isa_pkg::op_lui: return imm;
            rv_isa_pkg::op_auipc, rv_isa_pkg::op_jal, rv_isa_pkg::op_branch: return pc + imm;
            rv_isa_pkg::op_r, rv_isa_pkg::op_imm: begin
                case (inst[14:12])
                    3'd0: return (inst[6:0] == rv_isa_pkg::op_r && inst[30]) ? rd1 - b : rd1 + b;
                    3'd1: return rd1 << sh;
                    3'd2: return {31'd0, $signed(rd1) < $signed(b)};
                    3'd3: return {31'd0, rd1 < b};
                    3'd4: return rd1 ^ b;
                    3'd5: return inst[30] ? $unsigned($signed(rd1) >>> sh) : rd1 >> sh;
                    3'd6: return rd1 | b;
                    default: return rd1 & b;
                endcase
            end
            // Loads, stores, JALR and CSR ops all form rd1 + imm
            default: return rd1 + imm;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] rd1,
            input logic [31:0] rd2);
        case (f3)
            3'd0:    return rd1 == rd2;
            3'd1:    return rd1 != rd2;
            3'd4:    return $signed(rd1) < $signed(rd2);
            3'd5:    return $signed(rd1) >= $signed(rd2);
            3'd6:    return rd1 < rd2;
            default: return rd1 >= rd2;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s = 0x%08h, expected 0x%08h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    // Entered and left 5 ns after a rising edge
    task automatic run_inst(input logic [31:0] pc, input logic [31:0] inst,
            input logic [31:0] rd1, input logic [31:0] rd2, input logic br_taken);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        valid;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] exp_din;
        logic [3:0]  exp_we;
        logic        next_flush;
        int          lane;
        imm         = decode_imm(inst);
        ex_pc       = pc;
        ex_inst     = inst;
        ex_rd1      = rd1;
        ex_rd2      = rd2;
        ex_imm      = imm;
        ex_br_taken = br_taken;
        opc   = inst[6:0];
        f3    = inst[14:12];
        valid = !exp_flush;
        res   = expected_result(inst, pc, rd1, rd2, imm);
        exp_din = rd2;
        exp_we  = 4'b0000;
        if (opc == rv_isa_pkg::op_store && valid) begin
            case (f3)
                rv_isa_pkg::f3_sb: begin
                    exp_din = {4{rd2[7:0]}};
                    exp_we  = 4'b0001 << res[1:0];
                end
                rv_isa_pkg::f3_sh: begin
                    exp_din = {2{rd2[15:0]}};
                    exp_we  = res[1] ? 4'b1100 : 4'b0011;
                end
                default: exp_we = 4'b1111;
            endcase
        end
        next_flush = 1'b0;
        if (valid) begin
            case (opc)
                rv_isa_pkg::op_branch: next_flush = branch_taken(f3, rd1, rd2) != br_taken;
                rv_isa_pkg::op_jalr:   next_flush = 1'b1;
                rv_isa_pkg::op_jal:    next_flush = !br_taken;
                default:               next_flush = 1'b0;
            endcase
        end
        #45;
        check_value("ex_addr", ex_addr, res);
        check_value("ex_we", {28'd0, ex_we}, {28'd0, exp_we});
        if (exp_we != 4'b0000) begin
            check_value("ex_din", ex_din, exp_din);
        end
        @(posedge clk);
        #5;
        for (lane = 0; lane < 4; lane++) begin
            if (exp_we[lane]) begin
                shadow[res[5:2]][lane*8 +: 8] = exp_din[lane*8 +: 8];
            end
        end
        if (valid && opc == rv_isa_pkg::op_system && inst[31:20] == rv_isa_pkg::csr_tohost) begin
            if (f3 == rv_isa_pkg::f3_csrrw) begin
                exp_tohost = rd1;
            end else if (f3 == rv_isa_pkg::f3_csrrwi) begin
                exp_tohost = {27'd0, inst[19:15]};
            end
        end
        exp_flush = next_flush;
        check_value("wb_flush", {31'd0, wb_flush}, {31'd0, exp_flush});
        check_value("wb_inst", wb_inst, valid ? inst : rv_isa_pkg::nop);
        check_value("wb_alu", wb_alu, valid ? res : 32'd0);
        check_value("wb_pc4", wb_pc4, valid ? pc + 32'd4 : 32'd0);
        check_value("tohost", tohost, exp_tohost);
        if (valid && opc == rv_isa_pkg::op_load) begin
            check_value("wb_dmem_dout", wb_dmem_dout, shadow[res[5:2]]);
        end
    endtask

    // A nop never mispredicts, so the flush is clear after it
    task automatic settle();
        run_inst(rand32() & 32'hffff_fffc, rv_isa_pkg::nop, 32'd0, 32'd0, 1'b0);
    endtask

    task automatic access_mem(input logic is_store, input logic [2:0] f3,
            input logic [3:0] word, input logic [1:0] off, input logic [31:0] data);
        logic [31:0] inst;
        logic [31:0] target;
        inst   = make_inst(is_store ? rv_isa_pkg::op_store : rv_isa_pkg::op_load,
                           is_store ? f3 : 3'b010);
        target = mem_base | {26'd0, word, off};
        run_inst(rand32() & 32'hffff_fffc, inst, target - decode_imm(inst), data, 1'b0);
    endtask

    task automatic run_alu_tests();
        logic [31:0] inst;
        logic [31:0] r;
        int          kind;
        repeat (60) begin
            r    = rand32();
            kind = rand32() % 5;
            case (kind)
                0: begin
                    inst = make_inst(rv_isa_pkg::op_r, r[2:0]);
                    inst[31:25] = ((r[2:0] == 3'd0 || r[2:0] == 3'd5) && r[3]) ? 7'h20 : 7'h00;
                end
                1: begin
                    inst = make_inst(rv_isa_pkg::op_imm, r[2:0]);
                    if (r[2:0] == 3'd1 || r[2:0] == 3'd5) begin
                        inst[31:25] = (r[2:0] == 3'd5 && r[3]) ? 7'h20 : 7'h00;
                    end
                end
                2: inst = make_inst(rv_isa_pkg::op_lui, r[2:0]);
                3: inst = make_inst(rv_isa_pkg::op_auipc, r[2:0]);
                default: inst = make_inst(rv_isa_pkg::op_jal, r[2:0]);
            endcase
            run_inst(rand32() & 32'hffff_fffc, inst, rand32(), rand32(), r[4]);
        end
    endtask

    task automatic run_branch_tests();
        logic [31:0] inst;
        logic [31:0] r;
        logic [31:0] rd1;
        logic [2:0]  f3;
        repeat (60) begin
            r  = rand32();
            f3 = r[6:4];
            // funct3 2 and 3 are not branches
            if (f3[2:1] == 2'b01) begin
                f3[2] = 1'b1;
            end
            if (r[3:0] < 4'd3) begin
                inst = make_inst(rv_isa_pkg::op_jalr, 3'b000);
            end else begin
                inst = make_inst(rv_isa_pkg::op_branch, f3);
            end
            rd1 = rand32();
            run_inst(rand32() & 32'hffff_fffc, inst, rd1, r[8] ? rd1 : rand32(), r[9]);
        end
    endtask

    task automatic run_mem_tests();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [1:0]  off;
        settle();
        for (int w = 0; w < 16; w++) begin
            access_mem(1'b1, rv_isa_pkg::f3_sw, w[3:0], 2'd0, rand32());
        end
        repeat (60) begin
            r = rand32();
            if (r[4]) begin
                f3  = (r[6:5] == 2'd0) ? rv_isa_pkg::f3_sb :
                      (r[6:5] == 2'd1) ? rv_isa_pkg::f3_sh : rv_isa_pkg::f3_sw;
                off = (f3 == rv_isa_pkg::f3_sb) ? r[8:7] :
                      (f3 == rv_isa_pkg::f3_sh) ? {r[7], 1'b0} : 2'd0;
                access_mem(1'b1, f3, r[3:0], off, rand32());
            end else begin
                access_mem(1'b0, 3'd0, r[3:0], 2'd0, 32'd0);
            end
        end
        for (int w = 0; w < 16; w++) begin
            access_mem(1'b0, 3'd0, w[3:0], 2'd0, 32'd0);
        end
    endtask

    task automatic run_squash_tests();
        logic [31:0] inst;
        settle();
        // Taken BEQ predicted not taken, then a store that must not land
        run_inst(32'h0000_0400, make_inst(rv_isa_pkg::op_branch, rv_isa_pkg::f3_beq),
                 32'd5, 32'd5, 1'b0);
        check_value("wb_flush", {31'd0, wb_flush}, 32'd1);
        access_mem(1'b1, rv_isa_pkg::f3_sw, 4'd3, 2'd0, ~shadow[3]);
        // JALR, then a tohost write that must not land
        run_inst(32'h0000_0500, make_inst(rv_isa_pkg::op_jalr, 3'b000), rand32(), rand32(),
                 1'b1);
        check_value("wb_flush", {31'd0, wb_flush}, 32'd1);
        inst = make_inst(rv_isa_pkg::op_system, rv_isa_pkg::f3_csrrw);
        inst[31:20] = rv_isa_pkg::csr_tohost;
        run_inst(32'h0000_0504, inst, ~exp_tohost, 32'd0, 1'b0);
        // JAL predicted not taken
        run_inst(32'h0000_0600, make_inst(rv_isa_pkg::op_jal, 3'b000), 32'd0, 32'd0, 1'b0);
        check_value("wb_flush", {31'd0, wb_flush}, 32'd1);
        settle();
        settle();
        access_mem(1'b0, 3'd0, 4'd3, 2'd0, 32'd0);
    endtask

    task automatic run_csr_tests();
        logic [31:0] inst;
        logic [31:0] r;
        settle();
        repeat (30) begin
            r = rand32();
            inst = make_inst(rv_isa_pkg::op_system,
                             r[0] ? rv_isa_pkg::f3_csrrw : rv_isa_pkg::f3_csrrwi);
            if (r[3:1] == 3'd0) begin
                inst[31:20] = (r[31:20] == rv_isa_pkg::csr_tohost) ? r[31:20] ^ 12'h001
                                                                   : r[31:20];
            end else begin
                inst[31:20] = rv_isa_pkg::csr_tohost;
            end
            run_inst(rand32() & 32'hffff_fffc, inst, rand32(), rand32(), 1'b0);
        end
    endtask

    initial begin : stimulus
        reset       = 1'b1;
        ex_pc       = 32'd0;
        ex_inst     = rv_isa_pkg::nop;
        ex_rd1      = 32'd0;
        ex_rd2      = 32'd0;
        ex_imm      = 32'd0;
        ex_br_taken = 1'b0;
        exp_flush   = 1'b0;
        exp_tohost  = 32'd0;
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;
        check_value("wb_inst", wb_inst, rv_isa_pkg::nop);
        check_value("wb_flush", {31'd0, wb_flush}, 32'd0);
        check_value("tohost", tohost, 32'd0);
        check_value("wb_alu", wb_alu, 32'd0);
        check_value("wb_pc4", wb_pc4, 32'd0);
        run_alu_tests();
        run_branch_tests();
        run_mem_tests();
        run_squash_tests();
        run_csr_tests();
        done = 1'b1;
    end

    initial begin : finish_run
        int cycles;
        cycles = 0;
        while (!done && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("Timeout: stimulus did not finish within %0d cycles", max_cycles);
        end
        $display("Total errors: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period = 50
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [31:0]         a,
    input  logic [31:0]         b,
    input  logic [31:0]         rd1,
    input  logic [31:0]         rd2,
    input  ex_sel_pkg::alu_op_e op,
    input  logic                br_unsigned,
    output logic [31:0]         res,
    output logic                breq,
    output logic                brlt
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ex_sel_pkg::alu_add:    res = a + b;
            ex_sel_pkg::alu_sub:    res = a - b;
            ex_sel_pkg::alu_sll:    res = a << shamt;
            ex_sel_pkg::alu_slt:    res = {31'd0, $signed(a) < $signed(b)};
            ex_sel_pkg::alu_sltu:   res = {31'd0, a < b};
            ex_sel_pkg::alu_xor:    res = a ^ b;
            ex_sel_pkg::alu_srl:    res = a >> shamt;
            ex_sel_pkg::alu_sra:    res = $unsigned($signed(a) >>> shamt);
            ex_sel_pkg::alu_or:     res = a | b;
            ex_sel_pkg::alu_and:    res = a & b;
            ex_sel_pkg::alu_pass_b: res = b;
            default:                res = 32'd0;
        endcase
    end

    // Branch compare works on the register operands directly
    assign breq = rd1 == rd2;

    always_comb begin
        if (br_unsigned) begin
            brlt = rd1 < rd2;
        end else begin
            brlt = $signed(rd1) < $signed(rd2);
        end
    end

endmodule

// File: logic/dmem.sv
`timescale 1ns/1ps

module dmem #(
    parameter int dmem_addr_width = 12
) (
    input  logic                       clk,
    input  logic                       en,
    input  logic [3:0]                 we,
    input  logic [dmem_addr_width-1:0] addr,
    input  logic [31:0]                din,
    output logic [31:0]                dout
);

    logic [31:0] mem [0:(2**dmem_addr_width)-1];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][i*8 +: 8] <= din[i*8 +: 8];
                end
            end
            // Old contents on a same-cycle write
            dout <= mem[addr];
        end
    end

endmodule

// File: logic/ex_control.sv
`timescale 1ns/1ps

module ex_control (
    input  logic                clk,
    input  logic                reset,
    input  logic [31:0]         inst,
    input  logic [31:0]         rd1,
    input  logic [31:0]         imm,
    input  logic                breq,
    input  logic                brlt,
    input  logic                br_taken,
    output ex_sel_pkg::alu_op_e alu_op,
    output ex_sel_pkg::a_sel_e  a_sel,
    output ex_sel_pkg::b_sel_e  b_sel,
    output logic                br_unsigned,
    output ex_sel_pkg::size_e   store_size,
    output logic                dmem_en,
    output logic                store_en,
    output logic                ex_valid,
    output logic                wb_flush,
    output logic [31:0]         tohost
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       taken;
    logic       mispredict;
    logic       csr_write;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    // Squashed while the previous instruction is flushing
    assign ex_valid = ~wb_flush;

    always_comb begin
        alu_op = ex_sel_pkg::alu_add;
        a_sel  = ex_sel_pkg::a_reg;
        b_sel  = ex_sel_pkg::b_imm;
        case (opcode)
            rv_isa_pkg::op_r, rv_isa_pkg::op_imm: begin
                if (opcode == rv_isa_pkg::op_r) begin
                    b_sel = ex_sel_pkg::b_reg;
                end
                case (funct3)
                    rv_isa_pkg::f3_add_sub: begin
                        // Only the register form has sub
                        if (opcode == rv_isa_pkg::op_r && alt) begin
                            alu_op = ex_sel_pkg::alu_sub;
                        end
                    end
                    rv_isa_pkg::f3_sll:  alu_op = ex_sel_pkg::alu_sll;
                    rv_isa_pkg::f3_slt:  alu_op = ex_sel_pkg::alu_slt;
                    rv_isa_pkg::f3_sltu: alu_op = ex_sel_pkg::alu_sltu;
                    rv_isa_pkg::f3_xor:  alu_op = ex_sel_pkg::alu_xor;
                    rv_isa_pkg::f3_srl_sra: begin
                        alu_op = alt ? ex_sel_pkg::alu_sra : ex_sel_pkg::alu_srl;
                    end
                    rv_isa_pkg::f3_or:   alu_op = ex_sel_pkg::alu_or;
                    default:             alu_op = ex_sel_pkg::alu_and;
                endcase
            end
            rv_isa_pkg::op_lui: alu_op = ex_sel_pkg::alu_pass_b;
            // Targets relative to pc
            rv_isa_pkg::op_auipc, rv_isa_pkg::op_jal, rv_isa_pkg::op_branch: begin
                a_sel = ex_sel_pkg::a_pc;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_sb: store_size = ex_sel_pkg::size_byte;
            rv_isa_pkg::f3_sh: store_size = ex_sel_pkg::size_half;
            default:           store_size = ex_sel_pkg::size_word;
        endcase
    end

    assign store_en = ex_valid && opcode == rv_isa_pkg::op_store;
    assign dmem_en  = store_en || opcode == rv_isa_pkg::op_load;

    assign br_unsigned = funct3 == rv_isa_pkg::f3_bltu || funct3 == rv_isa_pkg::f3_bgeu;

    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_beq:  taken = breq;
            rv_isa_pkg::f3_bne:  taken = ~breq;
            rv_isa_pkg::f3_blt:  taken = brlt;
            rv_isa_pkg::f3_bge:  taken = ~brlt;
            rv_isa_pkg::f3_bltu: taken = brlt;
            rv_isa_pkg::f3_bgeu: taken = ~brlt;
            default:             taken = 1'b0;
        endcase
    end

    // JALR target is never predicted
    always_comb begin
        case (opcode)
            rv_isa_pkg::op_branch: mispredict = taken != br_taken;
            rv_isa_pkg::op_jalr:   mispredict = 1'b1;
            rv_isa_pkg::op_jal:    mispredict = ~br_taken;
            default:               mispredict = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_flush <= 1'b0;
        end else begin
            wb_flush <= ex_valid && mispredict;
        end
    end

    assign csr_write = ex_valid && opcode == rv_isa_pkg::op_system
                       && inst[31:20] == rv_isa_pkg::csr_tohost;

    always_ff @(posedge clk) begin
        if (reset) begin
            tohost <= 32'd0;
        end else if (csr_write) begin
            if (funct3 == rv_isa_pkg::f3_csrrw) begin
                tohost <= rd1;
            end else if (funct3 == rv_isa_pkg::f3_csrrwi) begin
                // zimm arrives in the low bits of the decoded immediate
                tohost <= {27'd0, imm[4:0]};
            end
        end
    end

endmodule

// File: logic/ex_sel_pkg.sv
package ex_sel_pkg;

    // ALU operation
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // Operand A source
    typedef enum logic {
        a_reg,
        a_pc
    } a_sel_e;

    // Operand B source
    typedef enum logic {
        b_reg,
        b_imm
    } b_sel_e;

    // Store width
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } size_e;

endpackage

// File: logic/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
    parameter int dmem_addr_width = 12
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] ex_pc,
    input  logic [31:0] ex_inst,
    input  logic [31:0] ex_rd1,
    input  logic [31:0] ex_rd2,
    input  logic [31:0] ex_imm,
    input  logic        ex_br_taken,
    output logic [31:0] ex_addr,
    output logic [31:0] ex_din,
    output logic [3:0]  ex_we,
    output logic [31:0] wb_pc4,
    output logic [31:0] wb_alu,
    output logic [31:0] wb_inst,
    output logic [31:0] wb_dmem_dout,
    output logic        wb_flush,
    output logic [31:0] tohost
);

    ex_sel_pkg::alu_op_e alu_op;
    ex_sel_pkg::a_sel_e  a_sel;
    ex_sel_pkg::b_sel_e  b_sel;
    ex_sel_pkg::size_e   store_size;
    logic                br_unsigned;
    logic                dmem_en;
    logic                store_en;
    logic                ex_valid;
    logic                breq;
    logic                brlt;
    logic [31:0]         alu_out;

    // ALU operand selection
    wire [31:0] alu_a = (a_sel == ex_sel_pkg::a_pc) ? ex_pc : ex_rd1;
    wire [31:0] alu_b = (b_sel == ex_sel_pkg::b_imm) ? ex_imm : ex_rd2;

    assign ex_addr = alu_out;

    ex_control control (
        .clk         (clk),
        .reset       (reset),
        .inst        (ex_inst),
        .rd1         (ex_rd1),
        .imm         (ex_imm),
        .breq        (breq),
        .brlt        (brlt),
        .br_taken    (ex_br_taken),
        .alu_op      (alu_op),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .br_unsigned (br_unsigned),
        .store_size  (store_size),
        .dmem_en     (dmem_en),
        .store_en    (store_en),
        .ex_valid    (ex_valid),
        .wb_flush    (wb_flush),
        .tohost      (tohost)
    );

    alu alu (
        .a           (alu_a),
        .b           (alu_b),
        .rd1         (ex_rd1),
        .rd2         (ex_rd2),
        .op          (alu_op),
        .br_unsigned (br_unsigned),
        .res         (alu_out),
        .breq        (breq),
        .brlt        (brlt)
    );

    mem_pack mem_pack (
        .data     (ex_rd2),
        .offset   (alu_out[1:0]),
        .size     (store_size),
        .store_en (store_en),
        .din      (ex_din),
        .we       (ex_we)
    );

    dmem #(
        .dmem_addr_width (dmem_addr_width)
    ) dmem (
        .clk  (clk),
        .en   (dmem_en),
        .we   (ex_we),
        .addr (alu_out[dmem_addr_width+1:2]),
        .din  (ex_din),
        .dout (wb_dmem_dout)
    );

    ex_wb_reg wb_reg (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .pc       (ex_pc),
        .inst     (ex_inst),
        .alu_res  (alu_out),
        .wb_pc4   (wb_pc4),
        .wb_inst  (wb_inst),
        .wb_alu   (wb_alu)
    );

endmodule

// File: logic/ex_wb_reg.sv
`timescale 1ns/1ps

module ex_wb_reg (
    input  logic        clk,
    input  logic        reset,
    input  logic        ex_valid,
    input  logic [31:0] pc,
    input  logic [31:0] inst,
    input  logic [31:0] alu_res,
    output logic [31:0] wb_pc4,
    output logic [31:0] wb_inst,
    output logic [31:0] wb_alu
);

    logic [31:0] pc4;

    assign pc4 = pc + 32'd4;

    // A squashed instruction becomes a bubble in writeback
    always_ff @(posedge clk) begin
        if (reset || !ex_valid) begin
            wb_pc4  <= 32'd0;
            wb_inst <= rv_isa_pkg::nop;
            wb_alu  <= 32'd0;
        end else begin
            wb_pc4  <= pc4;
            wb_inst <= inst;
            wb_alu  <= alu_res;
        end
    end

endmodule

// File: logic/mem_pack.sv
`timescale 1ns/1ps

module mem_pack (
    input  logic [31:0]       data,
    input  logic [1:0]        offset,
    input  ex_sel_pkg::size_e size,
    input  logic              store_en,
    output logic [31:0]       din,
    output logic [3:0]        we
);

    logic [3:0] lanes;

    always_comb begin
        case (size)
            ex_sel_pkg::size_byte: begin
                din   = {4{data[7:0]}};
                lanes = 4'b0001 << offset;
            end
            ex_sel_pkg::size_half: begin
                // Half-words sit on even byte pairs
                din   = {2{data[15:0]}};
                lanes = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                din   = data;
                lanes = 4'b1111;
            end
        endcase
    end

    assign we = store_en ? lanes : 4'b0000;

endmodule

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // ALU funct3, shared by register and immediate forms
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Store funct3
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    // CSR funct3
    localparam logic [2:0] f3_csrrw  = 3'b001;
    localparam logic [2:0] f3_csrrwi = 3'b101;

    localparam logic [11:0] csr_tohost = 12'h51E;

    // addi x0, x0, 0
    localparam logic [31:0] nop = 32'h0000_0013;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module ex_stage_tb -o ex_stage_sim || exit 1
out=$(./obj_dir/ex_stage_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "NO ERRORS" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}

// File: sources.f
logic/rv_isa_pkg.sv
logic/ex_sel_pkg.sv
logic/ex_control.sv
logic/alu.sv
logic/mem_pack.sv
logic/dmem.sv
logic/ex_wb_reg.sv
logic/ex_stage.sv
dv/tb_clock.sv
dv/ex_stage_tb.sv
